//--- dz_axil_regs.sv
// AXI4-Lite slave with CSR, RBUF/LPR and depth registers and the interrupt
`default_nettype none
`timescale 1ns/1ps

module dz_axil_regs import dz_pkg::*; #(
   parameter int NUM_LINES  = 8,
   parameter int SILO_DEPTH = 64
) (
   input  logic                        clk,
   input  logic                        rst,
   // Write channels
   input  logic [3:0]                  s_axil_awaddr,
   input  logic                        s_axil_awvalid,
   output logic                        s_axil_awready,
   input  logic [31:0]                 s_axil_wdata,
   input  logic                        s_axil_wvalid,
   output logic                        s_axil_wready,
   output logic [1:0]                  s_axil_bresp,
   output logic                        s_axil_bvalid,
   input  logic                        s_axil_bready,
   // Read channels
   input  logic [3:0]                  s_axil_araddr,
   input  logic                        s_axil_arvalid,
   output logic                        s_axil_arready,
   output logic [31:0]                 s_axil_rdata,
   output logic [1:0]                  s_axil_rresp,
   output logic                        s_axil_rvalid,
   input  logic                        s_axil_rready,
   // Silo side
   input  logic [$clog2(SILO_DEPTH):0] depth,
   input  logic                        alarm,
   input  dz_silo_word_t               head,
   input  logic                        head_ovr,
   output logic                        pop,
   output logic                        alarm_clr,
   output logic                        silo_clear,
   output logic                        scan_en,
   output logic [NUM_LINES-1:0]        rcvr_on,
   output logic                        irq
);

   typedef enum logic [1:0] {R_IDLE, R_WAIT, R_DATA} rd_state_t;

   rd_state_t   rd_state;
   logic [3:0]  rd_addr;
   logic        ne_q;        // silo not empty at AR time
   logic [31:0] rd_word;
   logic        wr_fire;
   logic        rie;
   logic        sae;
   logic        rdone;
   logic [15:0] csr;
   dz_word_u    rb;
   dz_word_u    lpr_w;

   ////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////

   // AW and W taken together while no response is pending
   assign wr_fire        = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
   assign s_axil_awready = wr_fire;
   assign s_axil_wready  = wr_fire;
   assign s_axil_bresp   = 2'b00;
   assign lpr_w          = s_axil_wdata[15:0];

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         s_axil_bvalid <= 1'b0;
         scan_en       <= 1'b0;
         rie           <= 1'b0;
         sae           <= 1'b0;
         silo_clear    <= 1'b0;
         rcvr_on       <= '0;
      end
      else
      begin
         silo_clear <= 1'b0;
         if (s_axil_bvalid && s_axil_bready)
            s_axil_bvalid <= 1'b0;
         if (wr_fire)
         begin
            s_axil_bvalid <= 1'b1;
            if (s_axil_awaddr == CSR_OFS)
            begin
               // Clear is a one-clock strobe
               silo_clear <= s_axil_wdata[CSR_CLR];
               scan_en    <= s_axil_wdata[CSR_MSE];
               rie        <= s_axil_wdata[CSR_RIE];
               sae        <= s_axil_wdata[CSR_SAE];
            end
            // LPR, receiver on/off for one line
            if (s_axil_awaddr == RBUF_OFS)
            begin
               for (int i = 0; i < NUM_LINES; i++)
                  if (lpr_w.lpr.line == LINE_W'(i))
                     rcvr_on[i] <= lpr_w.lpr.rcvr_on;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////////////

   assign rdone = (depth != '0);

   always_comb
   begin
      csr            = '0;
      csr[CSR_MSE]   = scan_en;
      csr[CSR_RIE]   = rie;
      csr[CSR_RDONE] = rdone;
      csr[CSR_SAE]   = sae;
      csr[CSR_SA]    = alarm;

      // RBUF fields only when a character is there
      rb = '0;
      if (ne_q)
      begin
         rb.rbuf.valid = 1'b1;
         rb.rbuf.ovr   = head_ovr;
         rb.rbuf.fe    = head.fe;
         rb.rbuf.line  = head.line;
         rb.rbuf.data  = head.data;
      end

      case (rd_addr)
         CSR_OFS:   rd_word = 32'(csr);
         RBUF_OFS:  rd_word = 32'(rb);
         DEPTH_OFS: rd_word = 32'(depth);
         default:   rd_word = '0;
      endcase
   end

   // Idle, wait on silo head, then hold data
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rd_state <= R_IDLE;
         rd_addr  <= '0;
         ne_q     <= 1'b0;
      end
      else
      begin
         case (rd_state)
            R_IDLE:
               if (s_axil_arvalid)
               begin
                  rd_addr  <= s_axil_araddr;
                  ne_q     <= rdone;
                  rd_state <= R_WAIT;
               end
            R_WAIT:
               rd_state <= R_DATA;
            default:
               if (s_axil_rready)
                  rd_state <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rd_state == R_WAIT)
         s_axil_rdata <= rd_word;
   end

   assign s_axil_arready = (rd_state == R_IDLE);
   assign s_axil_rvalid  = (rd_state == R_DATA);
   assign s_axil_rresp   = 2'b00;

   // Pop on the edge that raises RVALID
   assign pop       = (rd_state == R_WAIT) && (rd_addr == RBUF_OFS) && ne_q;
   // CSR read returns SA, then restarts the alarm count
   assign alarm_clr = (rd_state == R_WAIT) && (rd_addr == CSR_OFS);

   // Alarm or not-empty, chosen by SAE
   assign irq = rie && (sae ? alarm : rdone);

   a_rvalid_hold : assert property (@(posedge clk) disable iff (rst)
      s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid);
   a_bvalid_hold : assert property (@(posedge clk) disable iff (rst)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);

endmodule

`default_nettype wire

//--- dz_baud_timer.sv
// Shared prescaler producing the 16x oversample tick
`default_nettype none
`timescale 1ns/1ps

module dz_baud_timer #(
   parameter int CLK_DIV = 27
) (
   input  logic clk,
   input  logic rst,
   output logic tick
);

   // Counter width, at least one bit
   localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

   logic [CNT_W-1:0] cnt;

   // Down-counter, tick on terminal count
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cnt  <= CNT_W'(CLK_DIV - 1);
         tick <= 1'b0;
      end
      else if (cnt == '0)
      begin
         cnt  <= CNT_W'(CLK_DIV - 1);
         tick <= 1'b1;
      end
      else
      begin
         cnt  <= cnt - 1'b1;
         tick <= 1'b0;
      end
   end

   // Tick stays one clock wide for any divide above 1
   a_tick_single : assert property (@(posedge clk) disable iff (rst)
      (CLK_DIV > 1) && tick |=> !tick);

endmodule

`default_nettype wire

//--- dz_pkg.sv
// Shared register offsets, CSR bit positions, character types and the RBUF/LPR word union
`default_nettype none

package dz_pkg;

   ////////////////////////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////////////////////////

   // Byte offsets on the 4-bit AXI4-Lite address
   localparam logic [3:0] CSR_OFS   = 4'h0;
   localparam logic [3:0] RBUF_OFS  = 4'h4;
   localparam logic [3:0] DEPTH_OFS = 4'h8;

   // CSR bit positions
   localparam int CSR_CLR   = 4;
   localparam int CSR_MSE   = 5;
   localparam int CSR_RIE   = 6;
   localparam int CSR_RDONE = 7;
   localparam int CSR_SAE   = 12;
   localparam int CSR_SA    = 13;

   // Line number width, eight lines at most
   localparam int LINE_W = 3;

   ////////////////////////////////////////////////////////////////////
   // Data types
   ////////////////////////////////////////////////////////////////////

   // One character from a receiver
   typedef struct packed {
      logic       fe;
      logic [7:0] data;
   } dz_rx_char_t;

   // One silo entry, tagged with its line
   typedef struct packed {
      logic              fe;
      logic [LINE_W-1:0] line;
      logic [7:0]        data;
   } dz_silo_word_t;

   // Read view of offset 4
   typedef struct packed {
      logic              valid;
      logic              ovr;
      logic              fe;
      logic [1:0]        rsvd;
      logic [LINE_W-1:0] line;
      logic [7:0]        data;
   } dz_rbuf_t;

   // Write view of offset 4
   typedef struct packed {
      logic [2:0]        rsvd_hi;
      logic              rcvr_on;
      logic [8:0]        rsvd_lo;
      logic [LINE_W-1:0] line;
   } dz_lpr_t;

   // Same 16-bit word, decoded as RBUF or LPR
   typedef union packed {
      dz_rbuf_t rbuf;
      dz_lpr_t  lpr;
   } dz_word_u;

endpackage

`default_nettype wire

//--- dz_rx_top.sv
// Receive-side top connecting timer, line receivers, scanner, silo and registers
`default_nettype none
`timescale 1ns/1ps

module dz_rx_top import dz_pkg::*; #(
   parameter int NUM_LINES   = 8,
   parameter int CLK_DIV     = 27,
   parameter int SILO_DEPTH  = 64,
   parameter int ALARM_COUNT = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [3:0]           s_axil_awaddr,
   input  logic                 s_axil_awvalid,
   output logic                 s_axil_awready,
   input  logic [31:0]          s_axil_wdata,
   input  logic                 s_axil_wvalid,
   output logic                 s_axil_wready,
   output logic [1:0]           s_axil_bresp,
   output logic                 s_axil_bvalid,
   input  logic                 s_axil_bready,
   input  logic [3:0]           s_axil_araddr,
   input  logic                 s_axil_arvalid,
   output logic                 s_axil_arready,
   output logic [31:0]          s_axil_rdata,
   output logic [1:0]           s_axil_rresp,
   output logic                 s_axil_rvalid,
   input  logic                 s_axil_rready,
   input  logic [NUM_LINES-1:0] rx,
   output logic                 irq
);

   logic                        tick;
   logic [NUM_LINES-1:0]        rx_ready;
   logic [NUM_LINES-1:0]        rx_ack;
   logic [NUM_LINES-1:0]        rcvr_on;
   dz_rx_char_t                 rx_chars [NUM_LINES];
   logic                        push;
   dz_silo_word_t               push_word;
   logic                        pop;
   logic                        alarm_clr;
   logic                        silo_clear;
   logic                        scan_en;
   dz_silo_word_t               head;
   logic                        head_ovr;
   logic [$clog2(SILO_DEPTH):0] depth;
   logic                        alarm;

   dz_baud_timer #(.CLK_DIV(CLK_DIV)) u_timer (.clk, .rst, .tick);

   // One receiver per line
   for (genvar g = 0; g < NUM_LINES; g++)
   begin : g_line
      dz_uart_rx u_rx (
         .clk, .rst, .tick,
         .enable   (rcvr_on[g]),
         .ack      (rx_ack[g]),
         .rx       (rx[g]),
         .ready    (rx_ready[g]),
         .char_out (rx_chars[g])
      );
   end

   dz_scanner #(.NUM_LINES(NUM_LINES)) u_scanner (
      .clk, .rst, .scan_en,
      .clear (silo_clear),
      .ready (rx_ready),
      .chars (rx_chars),
      .ack   (rx_ack),
      .push, .push_word
   );

   dz_silo #(.SILO_DEPTH(SILO_DEPTH), .ALARM_COUNT(ALARM_COUNT)) u_silo (
      .clk, .rst,
      .clear (silo_clear),
      .push, .pop, .push_word, .alarm_clr, .head, .head_ovr, .depth, .alarm
   );

   dz_axil_regs #(.NUM_LINES(NUM_LINES), .SILO_DEPTH(SILO_DEPTH)) u_regs (
      .clk, .rst,
      .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
      .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
      .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
      .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
      .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
      .depth, .alarm, .head, .head_ovr,
      .pop, .alarm_clr, .silo_clear, .scan_en, .rcvr_on, .irq
   );

endmodule

`default_nettype wire

//--- dz_rx_trace.txt
# Records: T name | W offset data | F line char stop | R offset expect mask | Q irq
# All values hex, offsets are AXI4-Lite byte offsets (0 CSR, 4 RBUF/LPR, 8 depth)
T reset_state
R 0 0 ffff
R 8 0 ffff
R 4 0 8000
Q 0
T single_char
W 0 20
W 4 1002
F 2 5a 1
R 4 825a ffff
W 4 1001
F 2 33 1
F 1 c4 1
R 4 8233 ffff
R 4 81c4 ffff
F 3 77 1
R 4 0 8000
R 8 0 ffff
T framing_error
F 1 a5 0
R 4 a1a5 ffff
T silo_overrun
F 2 10 1
F 2 11 1
F 2 12 1
F 2 13 1
F 2 14 1
F 2 15 1
F 2 16 1
F 2 17 1
F 2 18 1
F 2 19 1
R 8 8 ffff
R 4 8210 ffff
R 4 8211 ffff
R 4 8212 ffff
R 4 8213 ffff
R 4 8214 ffff
R 4 8215 ffff
R 4 8216 ffff
R 4 8217 ffff
R 4 0 8000
F 2 3c 1
R 4 c23c ffff
T silo_alarm
W 0 1070
F 2 41 1
F 2 42 1
F 2 43 1
Q 0
F 2 44 1
Q 1
R 0 30e0 ffff
R 0 10e0 ffff
Q 0
W 0 60
Q 1
T clear
W 0 70
R 8 0 ffff
R 4 0 8000
R 0 60 ffff
Q 0

//--- dz_scanner.sv
// Round-robin scanner FSM moving received characters into the silo
`default_nettype none
`timescale 1ns/1ps

module dz_scanner import dz_pkg::*; #(
   parameter int NUM_LINES = 8
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 scan_en,
   input  logic                 clear,
   input  logic [NUM_LINES-1:0] ready,
   input  dz_rx_char_t          chars [NUM_LINES],
   output logic [NUM_LINES-1:0] ack,
   output logic                 push,
   output dz_silo_word_t        push_word
);

   typedef enum logic [1:0] {SCAN, PUSH, ACK} state_t;

   state_t            state;
   logic [LINE_W-1:0] idx;
   logic [LINE_W-1:0] idx_next;
   logic              sel_ready;
   dz_rx_char_t       sel_char;
   dz_silo_word_t     word_q;

   // Line select mux
   always_comb
   begin
      sel_ready = 1'b0;
      sel_char  = '0;
      for (int i = 0; i < NUM_LINES; i++)
      begin
         if (idx == LINE_W'(i))
         begin
            sel_ready = ready[i];
            sel_char  = chars[i];
         end
      end
   end

   // Wrap after the last line
   assign idx_next = (idx == LINE_W'(NUM_LINES - 1)) ? '0 : idx + 1'b1;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= SCAN;
         idx   <= '0;
      end
      else if (clear)
      begin
         state <= SCAN;
         idx   <= '0;
      end
      else
      begin
         case (state)
            SCAN:
               if (scan_en)
               begin
                  if (sel_ready)
                     state <= PUSH;
                  else
                     idx <= idx_next;
               end
            PUSH:
               state <= ACK;
            default:
            begin
               state <= SCAN;
               idx   <= idx_next;
            end
         endcase
      end
   end

   // Latched copy of the character being moved
   always_ff @(posedge clk)
   begin
      if (state == SCAN && sel_ready)
      begin
         word_q.fe   <= sel_char.fe;
         word_q.line <= idx;
         word_q.data <= sel_char.data;
      end
   end

   assign push      = (state == PUSH);
   assign push_word = word_q;

   // Ack back to the line just pushed
   always_comb
   begin
      for (int i = 0; i < NUM_LINES; i++)
         ack[i] = (state == ACK) && (idx == LINE_W'(i));
   end

endmodule

`default_nettype wire

//--- dz_silo.sv
// Character silo FIFO with overrun tagging and the silo alarm counter
`default_nettype none
`timescale 1ns/1ps

module dz_silo import dz_pkg::*; #(
   parameter int SILO_DEPTH  = 64,
   parameter int ALARM_COUNT = 16
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          clear,
   input  logic                          push,
   input  logic                          pop,
   input  dz_silo_word_t                 push_word,
   input  logic                          alarm_clr,
   output dz_silo_word_t                 head,
   output logic                          head_ovr,
   output logic [$clog2(SILO_DEPTH):0]   depth,
   output logic                          alarm
);

   localparam int AW = $clog2(SILO_DEPTH);
   localparam int CW = $clog2(ALARM_COUNT + 1);

   logic [AW-1:0] rd_ptr;
   logic [AW-1:0] wr_ptr;
   logic [12:0]   mem [SILO_DEPTH];   // overrun tag above the word
   logic [12:0]   head_q;
   logic          ovr_pend;
   logic [CW-1:0] alarm_cnt;
   logic          full;
   logic          do_push;
   logic          do_pop;

   assign full    = (depth == (AW+1)'(SILO_DEPTH));
   assign do_push = push && !full && !clear;
   assign do_pop  = pop && (depth != '0) && !clear;

   // Pointers, depth, pending overrun and alarm count
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rd_ptr    <= '0;
         wr_ptr    <= '0;
         depth     <= '0;
         ovr_pend  <= 1'b0;
         alarm_cnt <= '0;
      end
      else
      begin
         if (clear)
         begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            depth  <= '0;
         end
         else
         begin
            if (do_push)
               wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
               rd_ptr <= rd_ptr + 1'b1;
            depth <= depth + (AW+1)'(do_push) - (AW+1)'(do_pop);
         end

         // Lost character marks the next stored one
         if (clear)
            ovr_pend <= 1'b0;
         else if (push && full)
            ovr_pend <= 1'b1;
         else if (do_push)
            ovr_pend <= 1'b0;

         // Saturating count of stored characters
         if (clear || alarm_clr)
            alarm_cnt <= '0;
         else if (do_push && alarm_cnt != CW'(ALARM_COUNT))
            alarm_cnt <= alarm_cnt + 1'b1;
      end
   end

   // Dual-port memory, head read one clock behind rd_ptr
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= {ovr_pend, push_word};
      head_q <= mem[rd_ptr];
   end

   assign head     = dz_silo_word_t'(head_q[11:0]);
   assign head_ovr = head_q[12];
   assign alarm    = (alarm_cnt == CW'(ALARM_COUNT));

   a_depth_max : assert property (@(posedge clk) disable iff (rst)
      depth <= (AW+1)'(SILO_DEPTH));

endmodule

`default_nettype wire

//--- dz_uart_rx.sv
// Per-line 8N1 receiver with 16x oversampling and a character-ready hold register
`default_nettype none
`timescale 1ns/1ps

module dz_uart_rx import dz_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        tick,
   input  logic        enable,
   input  logic        ack,
   input  logic        rx,
   output logic        ready,
   output dz_rx_char_t char_out
);

   typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

   state_t     state;
   logic [3:0] sub;       // tick count within a bit
   logic [2:0] bit_idx;
   logic [7:0] shreg;
   logic       rx_meta;
   logic       rx_s;
   logic       rx_last;   // line level at previous tick
   logic       mid_bit;

   // Two-flop synchronizer, line idles high
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rx_meta <= 1'b1;
         rx_s    <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_s    <= rx_meta;
      end
   end

   // Sixteenth tick of a data or stop bit
   assign mid_bit = tick && (sub == 4'd15);

   ////////////////////////////////////////////////////////////////////
   // Frame FSM
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= S_IDLE;
         sub     <= '0;
         bit_idx <= '0;
         rx_last <= 1'b1;
         ready   <= 1'b0;
      end
      else
      begin
         // Scanner took the character
         if (ack)
            ready <= 1'b0;
         if (tick)
            rx_last <= rx_s;

         if (!enable)
            state <= S_IDLE;
         else if (tick)
         begin
            sub <= sub + 4'd1;
            case (state)
               S_IDLE:
               begin
                  sub <= '0;
                  // Falling edge starts a frame
                  if (rx_last && !rx_s)
                     state <= S_START;
               end
               S_START:
                  // Recheck at mid start bit, drop a glitch
                  if (sub == 4'd7)
                  begin
                     sub     <= '0;
                     bit_idx <= '0;
                     state   <= rx_s ? S_IDLE : S_DATA;
                  end
               S_DATA:
                  if (sub == 4'd15)
                  begin
                     bit_idx <= bit_idx + 3'd1;
                     if (bit_idx == 3'd7)
                        state <= S_STOP;
                  end
               default:
                  if (sub == 4'd15)
                  begin
                     ready <= 1'b1;
                     state <= S_IDLE;
                  end
            endcase
         end
      end
   end

   // Data shifts in LSB first, stop sample sets the error flag
   always_ff @(posedge clk)
   begin
      if (enable && mid_bit && state == S_DATA)
         shreg <= {rx_s, shreg[7:1]};
      if (enable && mid_bit && state == S_STOP)
      begin
         char_out.fe   <= !rx_s;
         char_out.data <= shreg;
      end
   end

   // Ack only for a character that is being held
   a_ack_ready : assert property (@(posedge clk) disable iff (rst) ack |-> ready);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the DZ receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_dz_rx -f tb.f
./obj_dir/Vtb_dz_rx > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
exit 0

//--- tb.f
dz_pkg.sv
dz_baud_timer.sv
dz_uart_rx.sv
dz_scanner.sv
dz_silo.sv
dz_axil_regs.sv
dz_rx_top.sv
tb_dz_rx.sv

//--- tb_dz_rx.sv
// Testbench for the DZ receive block, trace replay over serial lines and AXI4-Lite
`default_nettype none
`timescale 1ns/1ps

module tb_dz_rx import dz_pkg::*;;

   localparam int    NUM_LINES  = 4;
   localparam int    BIT_CLKS   = 32;   // 16 ticks of CLK_DIV 2
   localparam string TRACE_FILE = "dz_rx_trace.txt";

   logic        clk;
   logic        rst;
   logic [3:0]  s_axil_awaddr;
   logic        s_axil_awvalid;
   wire         s_axil_awready;
   logic [31:0] s_axil_wdata;
   logic        s_axil_wvalid;
   wire         s_axil_wready;
   wire  [1:0]  s_axil_bresp;
   wire         s_axil_bvalid;
   logic        s_axil_bready;
   logic [3:0]  s_axil_araddr;
   logic        s_axil_arvalid;
   wire         s_axil_arready;
   wire  [31:0] s_axil_rdata;
   wire  [1:0]  s_axil_rresp;
   wire         s_axil_rvalid;
   logic        s_axil_rready;
   logic [NUM_LINES-1:0] rx;
   wire         irq;

   // Parsed trace, one entry per record
   logic [7:0]        kind_q [$];
   logic [31:0]       a_q [$];
   logic [31:0]       b_q [$];
   logic [31:0]       c_q [$];
   logic [8*24-1:0]   name_q [$];

   int unsigned     lcg_state = 43508;
   int              watch_clks = 0;
   int              frame_cnt = 0;
   int              regop_cnt = 0;
   bit              trace_ok = 0;
   int              check_count = 0;
   int              fail_count = 0;
   int              test_count = 0;
   int              test_fails = 0;
   int              test_checks = 0;
   int              test_errs = 0;
   bit              test_open = 0;
   logic [8*24-1:0] cur_name;

   dz_rx_top #(
      .NUM_LINES   (NUM_LINES),
      .CLK_DIV     (2),
      .SILO_DEPTH  (8),
      .ALARM_COUNT (4)
   ) u_dut (
      .clk, .rst,
      .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
      .s_axil_wdata, .s_axil_wvalid, .s_axil_wready,
      .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
      .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
      .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
      .rx, .irq
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Watchdog, armed once the trace length is known
   initial
   begin
      wait (watch_clks > 0);
      repeat (watch_clks) @(posedge clk);
      $display("Timeout: the trace did not finish within %0d clocks", watch_clks);
      $display("TESTBENCH FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////

   // LCG, idle gap of 0 to 15 clocks
   function automatic int unsigned next_gap();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return (lcg_state >> 16) % 16;
   endfunction

   task automatic load_trace();
      int              fd;
      int              code;
      int              ch;
      bit              done;
      logic [7:0]      kind;
      logic [31:0]     a;
      logic [31:0]     b;
      logic [31:0]     c;
      logic [8*24-1:0] name;
      fd = $fopen(TRACE_FILE, "r");
      if (fd != 0)
      begin
         trace_ok = 1;
         done     = 0;
         while (!done)
         begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
               done = 1;
            else if (kind == "#")
            begin
               // Comment runs to end of line
               ch = $fgetc(fd);
               while (ch != 10 && ch != -1)
                  ch = $fgetc(fd);
            end
            else
            begin
               a    = '0;
               b    = '0;
               c    = '0;
               name = '0;
               case (kind)
                  "T":     code = $fscanf(fd, " %s", name);
                  "W":     code = $fscanf(fd, " %h %h", a, b);
                  "F":     code = $fscanf(fd, " %h %h %h", a, b, c);
                  "R":     code = $fscanf(fd, " %h %h %h", a, b, c);
                  "Q":     code = $fscanf(fd, " %h", a);
                  default: code = 0;
               endcase
               if (kind == "F")
                  frame_cnt++;
               else if (kind != "T")
                  regop_cnt++;
               kind_q.push_back(kind);
               a_q.push_back(a);
               b_q.push_back(b);
               c_q.push_back(c);
               name_q.push_back(name);
            end
         end
         $fclose(fd);
      end
   endtask

   // AW and W together, then wait for B
   task automatic axi_write(input logic [3:0] ofs, input logic [31:0] data);
      @(posedge clk);
      s_axil_awaddr  <= ofs;
      s_axil_awvalid <= 1'b1;
      s_axil_wdata   <= data;
      s_axil_wvalid  <= 1'b1;
      s_axil_bready  <= 1'b1;
      @(negedge clk);
      while (!s_axil_awready)
         @(negedge clk);
      // W goes in the same cycle as AW
      check_count++;
      test_checks++;
      if (s_axil_wready !== 1'b1)
      begin
         $display("FAIL at %0d ns: WREADY low while AWREADY is high", $time);
         fail_count++;
         test_errs++;
      end
      @(posedge clk);
      s_axil_awvalid <= 1'b0;
      s_axil_wvalid  <= 1'b0;
      @(negedge clk);
      while (!s_axil_bvalid)
         @(negedge clk);
      check_count++;
      test_checks++;
      if (s_axil_bresp !== 2'b00)
      begin
         $display("FAIL at %0d ns: BRESP expected 0 got %0d", $time, s_axil_bresp);
         fail_count++;
         test_errs++;
      end
      @(posedge clk);
      s_axil_bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] ofs, output logic [31:0] data);
      @(posedge clk);
      s_axil_araddr  <= ofs;
      s_axil_arvalid <= 1'b1;
      s_axil_rready  <= 1'b1;
      @(negedge clk);
      while (!s_axil_arready)
         @(negedge clk);
      @(posedge clk);
      s_axil_arvalid <= 1'b0;
      // Data sampled mid-cycle while RVALID is up
      @(negedge clk);
      while (!s_axil_rvalid)
         @(negedge clk);
      data = s_axil_rdata;
      check_count++;
      test_checks++;
      if (s_axil_rresp !== 2'b00)
      begin
         $display("FAIL at %0d ns: RRESP expected 0 got %0d", $time, s_axil_rresp);
         fail_count++;
         test_errs++;
      end
      @(posedge clk);
      s_axil_rready <= 1'b0;
   endtask

   // 8N1 frame, LSB first, then idle for a bit plus a random gap
   task automatic send_frame(input int line, input logic [7:0] ch, input logic stop);
      logic [9:0] bits;
      int         gap;
      bits = {stop, ch, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         rx[line] <= bits[i];
         repeat (BIT_CLKS - 1) @(posedge clk);
      end
      @(posedge clk);
      rx[line] <= 1'b1;
      gap = BIT_CLKS + int'(next_gap());
      repeat (gap) @(posedge clk);
   endtask

   task automatic check_read(input logic [3:0] ofs, input logic [31:0] exp,
                             input logic [31:0] mask);
      logic [31:0] got;
      axi_read(ofs, got);
      check_count++;
      test_checks++;
      if ((got & mask) !== (exp & mask))
      begin
         $display("FAIL at %0d ns: offset %0h expected %h got %h (mask %h)",
                  $time, ofs, exp & mask, got & mask, mask);
         fail_count++;
         test_errs++;
      end
   endtask

   task automatic check_irq(input logic exp);
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_count++;
      test_checks++;
      if (irq !== exp)
      begin
         $display("FAIL at %0d ns: irq expected %0b got %0b", $time, exp, irq);
         fail_count++;
         test_errs++;
      end
   endtask

   // One summary line per finished test
   task automatic close_test();
      if (test_open)
      begin
         test_count++;
         if (test_errs != 0)
            test_fails++;
         $display("Test %0s: %0s, %0d checks, %0d errors", cur_name,
                  (test_errs == 0) ? "ok" : "bad", test_checks, test_errs);
      end
      test_open = 0;
   endtask

   ////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////

   initial
   begin
      rst            = 1'b1;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      rx             = '1;
      load_trace();
      if (!trace_ok)
      begin
         $display("Trace file %0s could not be opened", TRACE_FILE);
         fail_count++;
      end
      else
      begin
         watch_clks = 400 * frame_cnt + 50 * regop_cnt + 100;
         repeat (5) @(posedge clk);
         rst <= 1'b0;
         repeat (2) @(posedge clk);
         for (int i = 0; i < kind_q.size(); i++)
         begin
            case (kind_q[i])
               "T":
               begin
                  close_test();
                  cur_name    = name_q[i];
                  test_open   = 1;
                  test_errs   = 0;
                  test_checks = 0;
               end
               "W": axi_write(a_q[i][3:0], b_q[i]);
               "F": send_frame(int'(a_q[i]), b_q[i][7:0], c_q[i][0]);
               "R": check_read(a_q[i][3:0], b_q[i], c_q[i]);
               "Q": check_irq(a_q[i][0]);
               default:
               begin
                  $display("Trace record %0d has an unknown kind", i);
                  fail_count++;
               end
            endcase
         end
         close_test();
      end
      $display("Tests %0d (%0d bad), checks %0d, failures %0d",
               test_count, test_fails, check_count, fail_count);
      if (fail_count == 0 && check_count > 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire
